// ==== include/fpmul_params.svh ====
`ifndef FPMUL_PARAMS_SVH
`define FPMUL_PARAMS_SVH

////////////////////////////////////////
// Result queue
////////////////////////////////////////
`define FPMUL_Q_DEPTH 4

////////////////////////////////////////
// Bus word addresses
////////////////////////////////////////
`define FPMUL_ADR_A    2'd0
`define FPMUL_ADR_B    2'd1
`define FPMUL_ADR_RES  2'd2
`define FPMUL_ADR_STAT 2'd3

// Canonical quiet NaN
`define FPMUL_QNAN 32'h7FC0_0000

`endif

// ==== source/fpmul_pkg.sv ====
package fpmul_pkg;

  ////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////
  typedef logic [31:0]        fp_word_t;  // Float or bus word
  typedef logic [7:0]         fp_exp_t;   // Biased exponent
  typedef logic [22:0]        fp_man_t;   // Stored fraction
  typedef logic [23:0]        sig_t;      // With hidden bit
  typedef logic [47:0]        prod_t;     // Significand product
  typedef logic signed [9:0]  sexp_t;     // Unbiased exponent

  typedef enum logic [2:0] {
    cls_zero,
    cls_sub,
    cls_inf,
    cls_nan,
    cls_norm
  } fp_class_e;

  ////////////////////////////////////////
  // Wishbone classic
  ////////////////////////////////////////
  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    logic [1:0] adr;    // Word address
    fp_word_t   dat_w;
  } wb_req_t;

  typedef struct packed {
    logic     ack;
    fp_word_t dat_r;
  } wb_rsp_t;

  // Stage 1 to stage 2
  typedef struct packed {
    logic     valid;
    logic     sign;       // Product sign
    sig_t     sig_a;
    sig_t     sig_b;
    sexp_t    exp_a;
    sexp_t    exp_b;
    logic     special;    // Bypass the arithmetic
    fp_word_t spec_word;
  } unpack_t;

  // Stage 2 to stage 3
  typedef struct packed {
    logic     valid;
    logic     sign;
    prod_t    prod;
    sexp_t    exp_sum;
    logic     special;
    fp_word_t spec_word;
  } product_t;

endpackage

// ==== source/fp_unpack.sv ====
`timescale 1ns/1ps
`include "fpmul_params.svh"

module fp_unpack import fpmul_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     issue,
  input  fp_word_t op_a,
  input  fp_word_t op_b,
  output unpack_t  stage_out
);

  fp_class_e cls_a, cls_b;
  logic      sign;
  logic      any_nan, any_inf, any_zero;
  fp_word_t  spec_word;

  function automatic fp_class_e classify(input fp_exp_t e, input fp_man_t m);
    if (e == '0) return (m == '0) ? cls_zero : cls_sub;
    if (e == '1) return (m == '0) ? cls_inf : cls_nan;
    return cls_norm;
  endfunction

  // Subnormals sit at the minimum exponent
  function automatic sexp_t unbias(input fp_exp_t e, input fp_class_e c);
    return (c == cls_sub) ? -10'sd126 : $signed({2'b00, e}) - 10'sd127;
  endfunction

  assign cls_a = classify(op_a[30:23], op_a[22:0]);
  assign cls_b = classify(op_b[30:23], op_b[22:0]);
  assign sign  = op_a[31] ^ op_b[31];

  assign any_nan  = (cls_a == cls_nan)  || (cls_b == cls_nan);
  assign any_inf  = (cls_a == cls_inf)  || (cls_b == cls_inf);
  assign any_zero = (cls_a == cls_zero) || (cls_b == cls_zero);

  assign spec_word = (any_nan || (any_inf && any_zero)) ? `FPMUL_QNAN :  // 0 * inf too
                     any_inf                            ? {sign, 8'hff, 23'h0} :
                                                          {sign, 31'h0};

  always_ff @(posedge clk) begin
    if (!rst_n) stage_out.valid <= 1'b0;
    else        stage_out.valid <= issue;
    if (issue) begin
      stage_out.sign      <= sign;
      stage_out.sig_a     <= {op_a[30:23] != '0, op_a[22:0]};  // Hidden bit
      stage_out.sig_b     <= {op_b[30:23] != '0, op_b[22:0]};
      stage_out.exp_a     <= unbias(op_a[30:23], cls_a);
      stage_out.exp_b     <= unbias(op_b[30:23], cls_b);
      stage_out.special   <= any_nan || any_inf || any_zero;
      stage_out.spec_word <= spec_word;
    end
  end

endmodule

// ==== source/fp_mant_mul.sv ====
`timescale 1ns/1ps

module fp_mant_mul import fpmul_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  unpack_t  stage_in,
  output product_t stage_out
);

  prod_t prod;
  sexp_t exp_sum;

  ////////////////////////////////////////
  // Significand product, exponent sum
  ////////////////////////////////////////
  // Product is 2.46 fixed point, value in [0, 4)
  assign prod = prod_t'(stage_in.sig_a) * prod_t'(stage_in.sig_b);

  // Range -252 to 254 fits the signed width
  assign exp_sum = stage_in.exp_a + stage_in.exp_b;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stage_out.valid <= 1'b0;
    end else begin
      stage_out.valid <= stage_in.valid;
    end
    if (stage_in.valid) begin
      stage_out.sign      <= stage_in.sign;
      stage_out.prod      <= prod;
      stage_out.exp_sum   <= exp_sum;
      stage_out.special   <= stage_in.special;    // Pass through
      stage_out.spec_word <= stage_in.spec_word;
    end
  end

endmodule

// ==== source/fp_norm_round.sv ====
`timescale 1ns/1ps

module fp_norm_round import fpmul_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  product_t stage_in,
  output logic     res_valid,
  output fp_word_t res_word
);

  logic [5:0]         lead_sh;    // Left shift to put the leading one at bit 47
  prod_t              norm_p;
  prod_t              den_p;
  logic signed [10:0] e_norm;     // Unbiased exponent after normalizing
  logic signed [10:0] den_amt;
  logic signed [10:0] exp_base;
  logic signed [10:0] exp_fin;
  logic               is_sub;
  logic               flush;
  logic               guard;
  logic [24:0]        rnd;
  fp_exp_t            exp_field;
  fp_man_t            frac;
  fp_word_t           result;

  ////////////////////////////////////////
  // Leading one detect
  ////////////////////////////////////////
  always_comb begin
    lead_sh = '0;
    for (int i = 0; i < 48; i++) begin
      if (stage_in.prod[i]) lead_sh = 6'(47 - i);  // Highest set bit wins
    end
  end

  ////////////////////////////////////////
  // Normalize, denormalize, round
  ////////////////////////////////////////
  always_comb begin
    norm_p = stage_in.prod << lead_sh;
    // Bit 47 of the product weighs 2^1
    e_norm = $signed({stage_in.exp_sum[9], stage_in.exp_sum}) + 11'sd1
             - $signed({5'b0, lead_sh});

    is_sub  = e_norm < -11'sd126;
    den_amt = -11'sd126 - e_norm;
    flush   = is_sub && (den_amt > 11'sd24);  // Below half the smallest subnormal
    den_p   = is_sub ? (norm_p >> den_amt) : norm_p;

    guard = den_p[23];
    rnd   = {1'b0, den_p[47:24]} + 25'(guard);  // Ties away from zero

    exp_base = is_sub ? 11'sd1 : e_norm + 11'sd127;
    if (rnd[24]) begin
      frac    = rnd[23:1];                  // Carry out, renormalize
      exp_fin = exp_base + 11'sd1;
    end else begin
      frac    = rnd[22:0];
      exp_fin = rnd[23] ? exp_base : 11'sd0;  // Subnormal may round up to normal
    end
    exp_field = exp_fin[7:0];

    if (stage_in.special) begin
      result = stage_in.spec_word;
    end else if (exp_fin > 11'sd254) begin
      result = {stage_in.sign, 8'hff, 23'h0};  // Overflow to infinity
    end else if (flush) begin
      result = {stage_in.sign, 31'h0};
    end else begin
      result = {stage_in.sign, exp_field, frac};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= stage_in.valid;
    end
    if (stage_in.valid) res_word <= result;
  end

endmodule

// ==== source/fpmul_wb_regs.sv ====
`timescale 1ns/1ps
`include "fpmul_params.svh"

module fpmul_wb_regs import fpmul_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  wb_req_t  wb_req,
  output wb_rsp_t  wb_rsp,
  output logic     issue,
  output fp_word_t op_a,
  output fp_word_t op_b,
  input  logic     res_valid,
  input  fp_word_t res_word
);

  localparam int PTR_W = $clog2(`FPMUL_Q_DEPTH);
  localparam int CNT_W = $clog2(`FPMUL_Q_DEPTH + 1);

  logic             ack_q;
  fp_word_t         dat_r_q;
  fp_word_t         a_q, b_q;
  fp_word_t         queue_mem [`FPMUL_Q_DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] q_count, in_flight;
  logic             req, b_write, room_full, accept, pop;
  fp_word_t         stat_word, rd_data;

  ////////////////////////////////////////
  // Bus decode
  ////////////////////////////////////////
  assign req       = wb_req.cyc && wb_req.stb && !ack_q;  // One ack per request
  assign b_write   = req && wb_req.we && (wb_req.adr == `FPMUL_ADR_B);
  assign room_full = ({1'b0, q_count} + {1'b0, in_flight}) == `FPMUL_Q_DEPTH;
  assign accept    = req && !(b_write && room_full);     // Hold B until room
  assign issue     = b_write && !room_full;
  assign pop       = accept && !wb_req.we && (wb_req.adr == `FPMUL_ADR_RES) &&
                     (q_count != '0);

  assign op_a = a_q;
  assign op_b = issue ? wb_req.dat_w : b_q;  // New B enters stage 1 this edge

  always_comb begin
    stat_word                = '0;
    stat_word[CNT_W-1:0]     = q_count;
    stat_word[8]             = in_flight != '0;  // Busy
    case (wb_req.adr)
      `FPMUL_ADR_A:   rd_data = a_q;
      `FPMUL_ADR_B:   rd_data = b_q;
      `FPMUL_ADR_RES: rd_data = (q_count != '0) ? queue_mem[rd_ptr] : '0;
      default:        rd_data = stat_word;
    endcase
  end

  ////////////////////////////////////////
  // Control state
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q     <= 1'b0;
      in_flight <= '0;
      q_count   <= '0;
      wr_ptr    <= '0;
      rd_ptr    <= '0;
    end else begin
      ack_q <= accept;
      if (issue && !res_valid)      in_flight <= in_flight + 1'b1;
      else if (!issue && res_valid) in_flight <= in_flight - 1'b1;
      if (res_valid) wr_ptr <= wr_ptr + 1'b1;  // Wraps with the power of two depth
      if (pop)       rd_ptr <= rd_ptr + 1'b1;
      if (res_valid && !pop)      q_count <= q_count + 1'b1;
      else if (!res_valid && pop) q_count <= q_count - 1'b1;
    end
  end

  // Operands, queue storage and read data
  always_ff @(posedge clk) begin
    if (res_valid) queue_mem[wr_ptr] <= res_word;
    if (accept && wb_req.we && (wb_req.adr == `FPMUL_ADR_A)) a_q <= wb_req.dat_w;
    if (issue) b_q <= wb_req.dat_w;
    if (accept && !wb_req.we) dat_r_q <= rd_data;
  end

  assign wb_rsp.ack   = ack_q;
  assign wb_rsp.dat_r = dat_r_q;

endmodule

// ==== source/fpmul_top.sv ====
`timescale 1ns/1ps

module fpmul_top import fpmul_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  wb_req_t wb_req,
  output wb_rsp_t wb_rsp
);

  logic     issue;
  fp_word_t op_a, op_b;
  unpack_t  s1;         // Unpack to multiply
  product_t s2;         // Multiply to normalize
  logic     res_valid;
  fp_word_t res_word;

  fpmul_wb_regs regs_i (
    .clk, .rst_n,
    .wb_req, .wb_rsp,
    .issue, .op_a, .op_b,
    .res_valid, .res_word
  );

  fp_unpack unpack_i (
    .clk, .rst_n, .issue, .op_a, .op_b,
    .stage_out (s1)
  );

  fp_mant_mul mul_i (
    .clk, .rst_n,
    .stage_in  (s1),
    .stage_out (s2)
  );

  fp_norm_round norm_i (
    .clk, .rst_n,
    .stage_in  (s2),
    .res_valid, .res_word
  );

endmodule

// ==== verif/fpmul_tb.sv ====
`timescale 1ns/1ps
`include "fpmul_params.svh"

module fpmul_tb import fpmul_pkg::*; ();

  localparam int DRIVE_DLY   = 2;   // ns after the rising edge
  localparam int HOLD_CYCLES = 8;   // Edges a held B write must stay unacked

  typedef struct packed {
    logic [7:0] kind;   // W, R or H
    logic [1:0] adr;
    fp_word_t   data;   // Write data or expected read data
  } trace_op_t;

  logic      clk;
  logic      rst_n;
  wb_req_t   wb_req;
  wb_rsp_t   wb_rsp;
  trace_op_t ops [$];
  int        cycles;
  int        limit;

  fpmul_top dut_i (
    .clk,
    .rst_n,
    .wb_req,
    .wb_rsp
  );

  always #20 clk = ~clk;

  // Cycle budget for the whole trace
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > limit) stop_with_failure("simulation timed out before the trace finished");
  end

  ////////////////////////////////////////
  // Failure and compare tasks
  ////////////////////////////////////////
  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input fp_word_t got, input fp_word_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error %0t ns: %s got %h expected %h",
                                  $time, name, got, exp));
    end
  endtask

  task automatic check_stat(input fp_word_t got, input fp_word_t exp);
    string field;
    field = "stat";
    if (got[2:0] !== exp[2:0]) field = "stat.count";  // Queue count
    else if (got[8] !== exp[8]) field = "stat.busy";
    if (got !== exp) begin
      stop_with_failure($sformatf("error %0t ns: %s got %h expected %h",
                                  $time, field, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // Wishbone master
  ////////////////////////////////////////
  task automatic drive_request(input logic we, input logic [1:0] adr, input fp_word_t data);
    @(posedge clk);
    #DRIVE_DLY;
    wb_req.cyc   = 1'b1;
    wb_req.stb   = 1'b1;
    wb_req.we    = we;
    wb_req.adr   = adr;
    wb_req.dat_w = data;
  endtask

  task automatic bus_access(input logic we, input logic [1:0] adr, input fp_word_t data,
                            output fp_word_t rdata);
    drive_request(we, adr, data);
    @(posedge clk);
    #DRIVE_DLY;
    while (!wb_rsp.ack) begin  // Stalled B writes wait here
      @(posedge clk);
      #DRIVE_DLY;
    end
    rdata  = wb_rsp.dat_r;
    wb_req = '0;
  endtask

  // Write that must not be acked while the queue is full, then withdrawn
  task automatic check_held(input logic [1:0] adr, input fp_word_t data);
    drive_request(1'b1, adr, data);
    repeat (HOLD_CYCLES) begin
      @(posedge clk);
      #DRIVE_DLY;
      if (wb_rsp.ack) stop_with_failure("B write was acked while the result queue was full");
    end
    wb_req = '0;
  endtask

  ////////////////////////////////////////
  // Trace
  ////////////////////////////////////////
  task automatic load_trace();
    int         fd;
    logic [7:0] kind;
    logic [1:0] adr;
    fp_word_t   data;
    fd = $fopen("verif/fpmul_trace.txt", "r");
    if (fd == 0) stop_with_failure("could not open the trace file verif/fpmul_trace.txt");
    while ($fscanf(fd, " %c %h %h", kind, adr, data) == 3) begin
      if (kind != "W" && kind != "R" && kind != "H") begin
        stop_with_failure($sformatf("trace holds an unknown record kind %c", kind));
      end
      ops.push_back({kind, adr, data});
    end
    if (!$feof(fd) || ops.size() == 0) begin
      stop_with_failure("trace file holds a line that cannot be read");
    end
    $fclose(fd);
  endtask

  task automatic run_op(input trace_op_t op);
    fp_word_t rdata;
    case (op.kind)
      "W": bus_access(1'b1, op.adr, op.data, rdata);
      "H": check_held(op.adr, op.data);
      default: begin
        bus_access(1'b0, op.adr, '0, rdata);
        case (op.adr)
          `FPMUL_ADR_A:   check_word("dat_r of operand A", rdata, op.data);
          `FPMUL_ADR_B:   check_word("dat_r of operand B", rdata, op.data);
          `FPMUL_ADR_RES: check_word("dat_r of result", rdata, op.data);
          `FPMUL_ADR_STAT: check_stat(rdata, op.data);
        endcase
      end
    endcase
  endtask

  initial begin
    clk    = 1'b0;
    rst_n  = 1'b0;
    wb_req = '0;
    cycles = 0;
    load_trace();
    limit = 30 * ops.size() + 100;
    repeat (8) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    foreach (ops[i]) run_op(ops[i]);
    $display("Regression passed");
    $finish;
  end

endmodule

// ==== verif/fpmul_trace.txt ====
R 3 00000000
W 0 3FC00000
W 1 40000000
R 0 3FC00000
R 1 40000000
W 0 BF800001
W 1 3FC00000
W 0 3FFFFFFE
W 1 3F800001
R 2 40400000
R 2 BFC00002
R 2 40000000
W 0 80000000
W 1 40400000
W 1 7F800000
W 0 7F800000
W 1 C0000000
W 0 FF800001
W 1 3F800000
R 2 80000000
R 2 7FC00000
R 2 FF800000
R 2 7FC00000
W 0 7F000000
W 1 40000000
W 0 00800000
W 1 3F000000
W 1 80800000
R 2 7F800000
R 2 00400000
R 2 80000000
W 0 40000000
W 1 3F800000
W 1 40400000
W 1 40800000
W 1 40A00000
H 1 40C00000
R 3 00000004
R 2 40000000
W 1 40C00000
R 2 40C00000
R 2 41000000
R 2 41200000
R 2 41400000
R 2 00000000
R 3 00000000

// ==== filelist.f ====
+incdir+include
source/fpmul_pkg.sv
source/fp_unpack.sv
source/fp_mant_mul.sv
source/fp_norm_round.sv
source/fpmul_wb_regs.sv
source/fpmul_top.sv
verif/fpmul_tb.sv

// ==== Bender.yml ====
package:
  name: fpmul

sources:
  - include_dirs:
      - include
    files:
      - source/fpmul_pkg.sv
      - source/fp_unpack.sv
      - source/fp_mant_mul.sv
      - source/fp_norm_round.sv
      - source/fpmul_wb_regs.sv
      - source/fpmul_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/fpmul_tb.sv
